/* verif/program.hex */
// one 32-bit instruction word per line, loaded from address 0 upward
// data area for the load and store checks sits at byte address 0x400
123450b7 // lui   x1, 0x12345
ffb00113 // addi  x2, x0, -5
00700193 // addi  x3, x0, 7
00308233 // add   x4, x1, x3
402182b3 // sub   x5, x3, x2
00312333 // slt   x6, x2, x3
003133b3 // sltu  x7, x2, x3
40115413 // srai  x8, x2, 1
01c15493 // srli  x9, x2, 28
00419513 // slli  x10, x3, 4
002245b3 // xor   x11, x4, x2
00001617 // auipc x12, 1
00518013 // addi  x0, x3, 5
40000693 // addi  x13, x0, 0x400
0046a023 // sw    x4, 0(x13)
002680a3 // sb    x2, 1(x13)
00a69123 // sh    x10, 2(x13)
00168703 // lb    x14, 1(x13)
0016c783 // lbu   x15, 1(x13)
00069803 // lh    x16, 0(x13)
0026d883 // lhu   x17, 2(x13)
0006a903 // lw    x18, 0(x13)
0ff0000f // fence
00318463 // beq   x3, x3, +8
00100993 // addi  x19, x0, 1
00319463 // bne   x3, x3, +8
00314463 // blt   x2, x3, +8
00200993 // addi  x19, x0, 2
00315463 // bge   x2, x3, +8
00316463 // bltu  x2, x3, +8
00317463 // bgeu  x2, x3, +8
00300993 // addi  x19, x0, 3
00800a6f // jal   x20, +8
00400993 // addi  x19, x0, 4
09400a93 // addi  x21, x0, 0x94
001a8b67 // jalr  x22, 1(x21)
00500993 // addi  x19, x0, 5
00a36bb3 // or    x23, x6, x10
00a17c33 // and   x24, x2, x10
fff13c93 // sltiu x25, x2, -1
00000073 // ecall

/* src.f */
verilog/rv_isa_pkg.sv
verilog/rv_core_pkg.sv
verilog/rv_decode.sv
verilog/rv_execute.sv
verilog/rv_mem_align.sv
verilog/rv_regfile.sv
verilog/rv_memory.sv
verilog/rv_core.sv
verif/rv_core_tb.sv

/* run.sh */
#!/bin/sh
# build and run the rv_core testbench with Verilator from the project root
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -f src.f --top-module rv_core_tb -o rv_core_sim \
  && ./obj_dir/rv_core_sim | grep "TEST OK" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* verif/rv_core_tb.sv */
/* Runs the rv_core program image, follows every retirement with a shadow
   register file and memory, and checks the trace with assertions. */
module rv_core_tb;
  import rv_isa_pkg::*;

  localparam int HALT_TIMEOUT = 2000;
  localparam int QUIET_CYCLES = 20;
  localparam logic [XLEN-1:0] ECALL_INSN = 32'h00000073;

  logic clk;
  logic rst;
  logic rst_q = 1'b0;
  logic halt, retire_valid, retire_we;
  logic [XLEN-1:0] retire_pc, retire_insn, retire_rd_data;
  logic [4:0] retire_rd;

  // shadow architectural state
  logic [XLEN-1:0] sregs [32];
  logic [XLEN-1:0] smem [2048];
  logic [XLEN-1:0] exp_pc;

  // prediction for the instruction on the trace port
  logic [6:0] op;
  logic [2:0] f3;
  logic [4:0] rd, rs1, rs2;
  logic [XLEN-1:0] a, b, imm_i, imm_s, imm_b, imm_u, imm_j, ea;
  logic exp_we;
  logic [XLEN-1:0] exp_data, exp_next, exp_insn;

  rv_core uut (
    .clk(clk),
    .rst(rst),
    .halt(halt),
    .retire_valid(retire_valid),
    .retire_pc(retire_pc),
    .retire_insn(retire_insn),
    .retire_rd(retire_rd),
    .retire_we(retire_we),
    .retire_rd_data(retire_rd_data)
  );

  always #4 clk = ~clk;

  always @(posedge clk) rst_q <= rst;

  function automatic logic [XLEN-1:0] compute_alu(input logic [2:0] fn, input logic alt,
                                                  input logic [XLEN-1:0] x,
                                                  input logic [XLEN-1:0] y);
    case (fn)
      3'd0: return alt ? x - y : x + y;
      3'd1: return x << y[4:0];
      3'd2: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      3'd3: return (x < y) ? 32'd1 : 32'd0;
      3'd4: return x ^ y;
      3'd5: return alt ? 32'($signed(x) >>> y[4:0]) : x >> y[4:0];
      3'd6: return x | y;
      default: return x & y;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] fn, input logic [XLEN-1:0] x,
                                        input logic [XLEN-1:0] y);
    case (fn)
      3'd0: return x == y;
      3'd1: return x != y;
      3'd4: return $signed(x) < $signed(y);
      3'd5: return $signed(x) >= $signed(y);
      3'd6: return x < y;
      default: return x >= y;
    endcase
  endfunction

  // byte offset picks the lane, funct3 the size and signedness
  function automatic logic [XLEN-1:0] extract_load(input logic [2:0] fn,
                                                   input logic [XLEN-1:0] word,
                                                   input logic [1:0] off);
    logic [XLEN-1:0] s;
    s = word >> (8 * off);
    case (fn)
      3'd0: return {{24{s[7]}}, s[7:0]};
      3'd1: return {{16{s[15]}}, s[15:0]};
      3'd4: return {24'b0, s[7:0]};
      3'd5: return {16'b0, s[15:0]};
      default: return word;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] final_value(input int idx);
    case (idx)
      1: return 32'h12345000;
      2: return 32'hfffffffb;
      3: return 32'h00000007;
      4: return 32'h12345007;
      5: return 32'h0000000c;
      6: return 32'h00000001;
      8: return 32'hfffffffd;
      9: return 32'h0000000f;
      10: return 32'h00000070;
      11: return 32'hedcbaffc;
      12: return 32'h0000102c;
      13: return 32'h00000400;
      14: return 32'hfffffffb;
      15: return 32'h000000fb;
      16: return 32'hfffffb07;
      17: return 32'h00000070;
      18: return 32'h0070fb07;
      20: return 32'h00000084;
      21: return 32'h00000094;
      22: return 32'h00000090;
      23: return 32'h00000071;
      24: return 32'h00000070;
      25: return 32'h00000001;
      default: return 32'h0;
    endcase
  endfunction

  task automatic report_error(input string msg);
    $display("ERR %0t: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "stopping at first error");
  endtask

  assign op    = retire_insn[6:0];
  assign f3    = retire_insn[14:12];
  assign rd    = retire_insn[11:7];
  assign rs1   = retire_insn[19:15];
  assign rs2   = retire_insn[24:20];
  assign a     = sregs[rs1];
  assign b     = sregs[rs2];
  assign imm_i = {{20{retire_insn[31]}}, retire_insn[31:20]};
  assign imm_s = {{20{retire_insn[31]}}, retire_insn[31:25], retire_insn[11:7]};
  assign imm_b = {{20{retire_insn[31]}}, retire_insn[7], retire_insn[30:25],
                  retire_insn[11:8], 1'b0};
  assign imm_u = {retire_insn[31:12], 12'b0};
  assign imm_j = {{12{retire_insn[31]}}, retire_insn[19:12], retire_insn[20],
                  retire_insn[30:21], 1'b0};
  assign ea    = a + ((op == OP_STORE) ? imm_s : imm_i);

  // the program image is never overwritten, so it tells which word sits at retire_pc
  assign exp_insn = smem[retire_pc[12:2]];

  always_comb begin
    exp_we   = 1'b0;
    exp_data = '0;
    exp_next = retire_pc + 32'd4;
    case (op)
      OP_LUI: begin
        exp_we   = 1'b1;
        exp_data = imm_u;
      end
      OP_AUIPC: begin
        exp_we   = 1'b1;
        exp_data = retire_pc + imm_u;
      end
      OP_JAL: begin
        exp_we   = 1'b1;
        exp_data = retire_pc + 32'd4;
        exp_next = retire_pc + imm_j;
      end
      OP_JALR: begin
        exp_we   = 1'b1;
        exp_data = retire_pc + 32'd4;
        exp_next = (a + imm_i) & ~32'd1;
      end
      OP_BRANCH: begin
        if (branch_taken(f3, a, b)) begin
          exp_next = retire_pc + imm_b;
        end
      end
      OP_LOAD: begin
        exp_we   = 1'b1;
        exp_data = extract_load(f3, smem[ea[12:2]], ea[1:0]);
      end
      OP_IMM: begin
        exp_we   = 1'b1;
        exp_data = compute_alu(f3, retire_insn[30] && f3 == 3'd5, a, imm_i);
      end
      OP_REG: begin
        exp_we   = 1'b1;
        exp_data = compute_alu(f3, retire_insn[30], a, b);
      end
      default: exp_we = 1'b0;
    endcase
  end

  initial $readmemh("verif/program.hex", smem);

  // shadow state advances on the same edge the core retires
  always @(posedge clk) begin
    if (rst) begin
      exp_pc <= '0;
      for (int i = 0; i < 32; i++) begin
        sregs[i] <= '0;
      end
    end else if (retire_valid) begin
      exp_pc <= exp_next;
      if (exp_we && rd != 5'd0) begin
        sregs[rd] <= exp_data;
      end
      if (op == OP_STORE) begin
        case (f3)
          3'd0: smem[ea[12:2]][8*ea[1:0] +: 8] <= b[7:0];
          3'd1: smem[ea[12:2]][16*ea[1] +: 16] <= b[15:0];
          default: smem[ea[12:2]] <= b;
        endcase
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clk) rst_q |-> (!retire_valid && !halt))
    else report_error("retire or halt active around reset");
  a_pc: assert property (@(posedge clk) disable iff (rst) retire_valid |-> retire_pc == exp_pc)
    else report_error($sformatf("retire_pc %h, expected %h", retire_pc, exp_pc));
  a_insn: assert property (@(posedge clk) disable iff (rst)
                           retire_valid |-> retire_insn == exp_insn)
    else report_error($sformatf("retire_insn %h, expected %h at pc %h",
                                retire_insn, exp_insn, retire_pc));
  a_we: assert property (@(posedge clk) disable iff (rst) retire_valid |-> retire_we == exp_we)
    else report_error($sformatf("retire_we %b at pc %h", retire_we, retire_pc));
  a_rd: assert property (@(posedge clk) disable iff (rst)
                         (retire_valid && exp_we) |-> retire_rd == rd)
    else report_error($sformatf("retire_rd %0d, expected %0d", retire_rd, rd));
  a_data: assert property (@(posedge clk) disable iff (rst)
                           (retire_valid && exp_we) |-> retire_rd_data == exp_data)
    else report_error($sformatf("rd_data %h, expected %h at pc %h",
                                retire_rd_data, exp_data, retire_pc));
  a_halted: assert property (@(posedge clk) disable iff (rst) halt |-> !retire_valid)
    else report_error("retire after halt");
  // halt comes up exactly one cycle after ECALL retires
  a_ecall_halt: assert property (@(posedge clk) disable iff (rst)
      $rose(halt) |-> $past(retire_valid && retire_insn == ECALL_INSN))
    else report_error("halt rose without an ECALL retiring the cycle before");

  initial begin
    int waited;
    int bad;
    clk = 1'b0;
    rst = 1'b1;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    waited = 0;
    while (!halt && waited < HALT_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (!halt) begin
      $display("core did not halt within %0d cycles", HALT_TIMEOUT);
      $display("TEST FAILED");
      $fatal(1, "hang");
    end
    for (int i = 0; i < QUIET_CYCLES; i++) begin
      @(posedge clk);
    end
    bad = -1;
    for (int i = 31; i >= 0; i--) begin
      if (sregs[i] !== final_value(i) || uut.u_regfile.regs[i] !== final_value(i)) begin
        bad = i;
      end
    end
    if (bad >= 0) begin
      report_error($sformatf("final x%0d is %h, expected %h", bad,
                             uut.u_regfile.regs[bad], final_value(bad)));
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

/* verilog/rv_core.sv */
/* Multi-cycle RV32I core with on-chip memory and a retire trace port.
   Drive clk and rst; watch halt and the retire_* strobe. */
module rv_core (
  input  logic                              clk,
  input  logic                              rst,
  output logic                              halt,
  output logic                              retire_valid,
  output logic [rv_isa_pkg::XLEN-1:0]       retire_pc,
  output logic [rv_isa_pkg::XLEN-1:0]       retire_insn,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0] retire_rd,
  output logic                              retire_we,
  output logic [rv_isa_pkg::XLEN-1:0]       retire_rd_data
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  core_state_e state;
  logic [XLEN-1:0] pc, pc_plus4, insn, load_addr_q, align_addr;
  logic [XLEN-1:0] rs1_data, rs2_data, imm, alu_result, next_pc, mem_addr, rd_data;
  logic [XLEN-1:0] dmem_addr, dmem_wdata, dmem_rdata;
  logic [3:0] dmem_we;
  logic [REG_ADDR_W-1:0] rd_addr, rs1_addr, rs2_addr;
  logic [2:0] funct3;
  opcode_e opcode;
  alu_op_e alu_op;
  mem_size_e mem_size;
  wb_src_e wb_src;
  logic use_imm, is_branch, is_jal, is_jalr, is_auipc, is_lui;
  logic is_load, is_store, load_unsigned, reg_we, is_ecall;
  logic retire, store_en, rf_we;

  // the memory keeps reading at pc, so insn holds through EXEC and LOAD_WB
  rv_memory u_memory (.*, .fetch_pc(pc));

  rv_decode u_decode (.*);

  rv_execute u_execute (.*);

  rv_mem_align u_mem_align (.*, .is_store(store_en), .mem_addr(align_addr));

  rv_regfile u_regfile (.*, .we(rf_we));

  assign pc_plus4 = pc + 32'd4;

  // loads retire one state later, once the synchronous read returns
  assign retire   = (state == ST_EXEC && !is_load) || (state == ST_LOAD_WB);
  assign store_en = is_store && (state == ST_EXEC);
  assign rf_we    = reg_we && retire;

  assign align_addr = (state == ST_LOAD_WB) ? load_addr_q : mem_addr;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_FETCH;
      pc    <= '0;
    end else begin
      case (state)
        ST_FETCH: state <= ST_EXEC;
        ST_EXEC: begin
          // ecall leaves pc on itself so the halted fetch stays harmless
          if (is_ecall) begin
            state <= ST_HALTED;
          end else if (is_load) begin
            state <= ST_LOAD_WB;
          end else begin
            state <= ST_FETCH;
            pc    <= next_pc;
          end
        end
        ST_LOAD_WB: begin
          state <= ST_FETCH;
          pc    <= next_pc;
        end
        default: state <= ST_HALTED;
      endcase
    end
  end

  // byte offset for load extraction in LOAD_WB
  always_ff @(posedge clk) begin
    if (state == ST_EXEC) begin
      load_addr_q <= mem_addr;
    end
  end

  assign halt = (state == ST_HALTED);

  assign retire_valid   = retire;
  assign retire_pc      = pc;
  assign retire_insn    = insn;
  assign retire_rd      = rd_addr;
  assign retire_we      = reg_we;
  assign retire_rd_data = rd_data;

  a_no_retire_halted: assert property (
    @(posedge clk) disable iff (rst) (state == ST_HALTED) |-> !retire_valid
  ) else $error("retire while halted, pc %h", pc);

  // the instruction word must stay put while the load data comes back
  a_load_insn_held: assert property (
    @(posedge clk) disable iff (rst) (state == ST_LOAD_WB) |-> (opcode == OP_LOAD)
  ) else $error("instruction changed during load writeback, pc %h", pc);

endmodule

/* verilog/rv_memory.sv */
/* Unified word memory, preloaded with the program image. Instruction and
   data reads take one cycle; data writes are byte-masked and read-first. */
module rv_memory (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [rv_isa_pkg::XLEN-1:0] fetch_pc,
  input  logic [rv_isa_pkg::XLEN-1:0] dmem_addr,
  input  logic [rv_isa_pkg::XLEN-1:0] dmem_wdata,
  input  logic [3:0]                  dmem_we,
  output logic [rv_isa_pkg::XLEN-1:0] insn,
  output logic [rv_isa_pkg::XLEN-1:0] dmem_rdata
);
  import rv_isa_pkg::*;

  logic [XLEN-1:0] mem [MEM_WORDS];
  logic [$clog2(MEM_WORDS)-1:0] fetch_idx, data_idx;

  initial begin
    $readmemh("verif/program.hex", mem);
  end

  // byte addresses in, word indices out; upper bits wrap
  assign fetch_idx = fetch_pc[$clog2(MEM_WORDS)+1:2];
  assign data_idx  = dmem_addr[$clog2(MEM_WORDS)+1:2];

  always_ff @(posedge clk) begin
    insn       <= mem[fetch_idx];
    dmem_rdata <= mem[data_idx];
    for (int b = 0; b < 4; b++) begin
      if (dmem_we[b]) begin
        mem[data_idx][8*b +: 8] <= dmem_wdata[8*b +: 8];
      end
    end
  end

  a_fetch_aligned: assert property (
    @(posedge clk) disable iff (rst) fetch_pc[1:0] == 2'b00
  ) else $error("unaligned fetch at %h", fetch_pc);

endmodule

/* verilog/rv_regfile.sv */
/* 32 x 32-bit register file, two combinational read ports and one
   write port; x0 always reads zero. */
module rv_regfile (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              we,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rd_addr,
  input  logic [rv_isa_pkg::XLEN-1:0]       rd_data,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_addr,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2_addr,
  output logic [rv_isa_pkg::XLEN-1:0]       rs1_data,
  output logic [rv_isa_pkg::XLEN-1:0]       rs2_data
);
  import rv_isa_pkg::*;

  logic [XLEN-1:0] regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd_addr != '0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

endmodule

/* verilog/rv_mem_align.sv */
/* Data-side alignment: store lane placement and byte strobes, load
   extraction with sign or zero extension, and writeback selection. */
module rv_mem_align (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        is_load,
  input  logic                        is_store,
  input  rv_core_pkg::mem_size_e      mem_size,
  input  logic                        load_unsigned,
  input  rv_core_pkg::wb_src_e        wb_src,
  input  logic [rv_isa_pkg::XLEN-1:0] mem_addr,
  input  logic [rv_isa_pkg::XLEN-1:0] rs2_data,
  input  logic [rv_isa_pkg::XLEN-1:0] dmem_rdata,
  input  logic [rv_isa_pkg::XLEN-1:0] alu_result,
  input  logic [rv_isa_pkg::XLEN-1:0] pc_plus4,
  output logic [rv_isa_pkg::XLEN-1:0] dmem_addr,
  output logic [rv_isa_pkg::XLEN-1:0] dmem_wdata,
  output logic [3:0]                  dmem_we,
  output logic [rv_isa_pkg::XLEN-1:0] rd_data
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  logic [1:0] offset;
  logic [XLEN-1:0] lane, load_val;

  assign offset    = mem_addr[1:0];
  assign dmem_addr = {mem_addr[XLEN-1:2], 2'b00};

  // replicate so the addressed lane always holds the store data
  always_comb begin
    case (mem_size)
      SZ_BYTE: dmem_wdata = {4{rs2_data[7:0]}};
      SZ_HALF: dmem_wdata = {2{rs2_data[15:0]}};
      default: dmem_wdata = rs2_data;
    endcase
  end

  always_comb begin
    dmem_we = 4'b0000;
    if (is_store) begin
      case (mem_size)
        SZ_BYTE: dmem_we = 4'b0001 << offset;
        SZ_HALF: dmem_we = 4'b0011 << {offset[1], 1'b0};
        default: dmem_we = 4'b1111;
      endcase
    end
  end

  // shift the addressed byte or halfword down to bit 0
  assign lane = dmem_rdata >> {offset, 3'b000};

  always_comb begin
    case (mem_size)
      SZ_BYTE: load_val = {{24{~load_unsigned & lane[7]}}, lane[7:0]};
      SZ_HALF: load_val = {{16{~load_unsigned & lane[15]}}, lane[15:0]};
      default: load_val = dmem_rdata;
    endcase
  end

  always_comb begin
    case (wb_src)
      WB_LOAD: rd_data = load_val;
      WB_PC4:  rd_data = pc_plus4;
      default: rd_data = alu_result;
    endcase
  end

  a_we_only_on_store: assert property (
    @(posedge clk) disable iff (rst) (dmem_we != 4'b0000) |-> (is_store && !is_load)
  ) else $error("byte strobes %b outside a store", dmem_we);

endmodule

/* verilog/rv_execute.sv */
/* Execute stage: ALU, branch compare, next-PC select and the load/store
   effective address. Purely combinational apart from its assertion. */
module rv_execute (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [rv_isa_pkg::XLEN-1:0] pc,
  input  logic [rv_isa_pkg::XLEN-1:0] rs1_data,
  input  logic [rv_isa_pkg::XLEN-1:0] rs2_data,
  input  logic [rv_isa_pkg::XLEN-1:0] imm,
  input  logic [2:0]                  funct3,
  input  rv_core_pkg::alu_op_e        alu_op,
  input  logic                        use_imm,
  input  logic                        is_branch,
  input  logic                        is_jal,
  input  logic                        is_jalr,
  input  logic                        is_auipc,
  input  logic                        is_lui,
  output logic [rv_isa_pkg::XLEN-1:0] alu_result,
  output logic [rv_isa_pkg::XLEN-1:0] next_pc,
  output logic [rv_isa_pkg::XLEN-1:0] mem_addr
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  logic [XLEN-1:0] op_b, alu_out, pc_plus4, pc_rel;
  logic [4:0] shamt;
  logic taken;

  assign op_b  = use_imm ? imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (alu_op)
      ALU_ADD:  alu_out = rs1_data + op_b;
      ALU_SUB:  alu_out = rs1_data - op_b;
      ALU_SLL:  alu_out = rs1_data << shamt;
      ALU_SLT:  alu_out = {{(XLEN-1){1'b0}}, $signed(rs1_data) < $signed(op_b)};
      ALU_SLTU: alu_out = {{(XLEN-1){1'b0}}, rs1_data < op_b};
      ALU_XOR:  alu_out = rs1_data ^ op_b;
      ALU_SRL:  alu_out = rs1_data >> shamt;
      ALU_SRA:  alu_out = $signed(rs1_data) >>> shamt;
      ALU_OR:   alu_out = rs1_data | op_b;
      ALU_AND:  alu_out = rs1_data & op_b;
      default:  alu_out = '0;
    endcase
  end

  // pc + imm serves AUIPC as well as branch and JAL targets
  assign pc_rel   = pc + imm;
  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    if (is_lui) begin
      alu_result = imm;
    end else if (is_auipc) begin
      alu_result = pc_rel;
    end else begin
      alu_result = alu_out;
    end
  end

  // loads, stores and JALR all use rs1 + imm
  assign mem_addr = rs1_data + imm;

  always_comb begin
    case (funct3)
      F3_BEQ:  taken = (rs1_data == rs2_data);
      F3_BNE:  taken = (rs1_data != rs2_data);
      F3_BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
      F3_BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      F3_BLTU: taken = (rs1_data < rs2_data);
      F3_BGEU: taken = (rs1_data >= rs2_data);
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    if (is_jal || (is_branch && taken)) begin
      next_pc = pc_rel;
    end else if (is_jalr) begin
      next_pc = {mem_addr[XLEN-1:1], 1'b0};
    end else begin
      next_pc = pc_plus4;
    end
  end

  // no compressed instructions, so every target lands on a word
  a_next_pc_aligned: assert property (
    @(posedge clk) disable iff (rst) next_pc[1:0] == 2'b00
  ) else $error("misaligned next_pc %h at pc %h", next_pc, pc);

endmodule

/* verilog/rv_decode.sv */
/* Combinational RV32I decoder: instruction fields, sign-extended immediate
   and the control bits for execute, memory alignment and the register file. */
module rv_decode (
  input  logic [rv_isa_pkg::XLEN-1:0]       insn,
  output rv_isa_pkg::opcode_e               opcode,
  output logic [2:0]                        funct3,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0] rd_addr,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_addr,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2_addr,
  output logic [rv_isa_pkg::XLEN-1:0]       imm,
  output rv_core_pkg::alu_op_e              alu_op,
  output logic                              use_imm,
  output logic                              is_branch,
  output logic                              is_jal,
  output logic                              is_jalr,
  output logic                              is_auipc,
  output logic                              is_lui,
  output logic                              is_load,
  output logic                              is_store,
  output rv_core_pkg::mem_size_e            mem_size,
  output logic                              load_unsigned,
  output rv_core_pkg::wb_src_e              wb_src,
  output logic                              reg_we,
  output logic                              is_ecall
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  logic [6:0] funct7;
  logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode   = opcode_e'(insn[6:0]);
  assign funct3   = insn[14:12];
  assign funct7   = insn[31:25];
  assign rd_addr  = insn[11:7];
  assign rs1_addr = insn[19:15];
  assign rs2_addr = insn[24:20];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};

  always_comb begin
    case (opcode)
      OP_STORE:         imm = imm_s;
      OP_BRANCH:        imm = imm_b;
      OP_LUI, OP_AUIPC: imm = imm_u;
      OP_JAL:           imm = imm_j;
      default:          imm = imm_i;
    endcase
  end

  // SUB only exists in the register form, SRAI shares funct7 with SRA
  always_comb begin
    alu_op = ALU_ADD;
    if (opcode == OP_REG || opcode == OP_IMM) begin
      case (funct3)
        F3_ADD:  alu_op = (opcode == OP_REG && funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
        F3_SLL:  alu_op = ALU_SLL;
        F3_SLT:  alu_op = ALU_SLT;
        F3_SLTU: alu_op = ALU_SLTU;
        F3_XOR:  alu_op = ALU_XOR;
        F3_SR:   alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
        F3_OR:   alu_op = ALU_OR;
        F3_AND:  alu_op = ALU_AND;
      endcase
    end
  end

  assign use_imm   = (opcode == OP_IMM);
  assign is_branch = (opcode == OP_BRANCH);
  assign is_jal    = (opcode == OP_JAL);
  assign is_jalr   = (opcode == OP_JALR);
  assign is_auipc  = (opcode == OP_AUIPC);
  assign is_lui    = (opcode == OP_LUI);
  assign is_load   = (opcode == OP_LOAD);
  assign is_store  = (opcode == OP_STORE);
  assign is_ecall  = (opcode == OP_SYSTEM) && (insn[31:7] == '0);

  assign mem_size      = (funct3[1:0] == 2'b00) ? SZ_BYTE :
                         (funct3[1:0] == 2'b01) ? SZ_HALF : SZ_WORD;
  assign load_unsigned = funct3[2];

  always_comb begin
    if (is_jal || is_jalr) begin
      wb_src = WB_PC4;
    end else if (is_load) begin
      wb_src = WB_LOAD;
    end else begin
      wb_src = WB_ALU;
    end
  end

  // branches, stores, fence and system write nothing
  always_comb begin
    case (opcode)
      OP_LOAD, OP_IMM, OP_REG, OP_LUI, OP_AUIPC, OP_JAL, OP_JALR: reg_we = 1'b1;
      default: reg_we = 1'b0;
    endcase
  end

endmodule

/* verilog/rv_core_pkg.sv */
/* Core-internal encodings: sequencer states, ALU operations, access sizes
   and writeback sources. Used inside the core only. */
package rv_core_pkg;

  typedef enum logic [1:0] {
    ST_FETCH,
    ST_EXEC,
    ST_LOAD_WB,
    ST_HALTED
  } core_state_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  // encoding matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    SZ_BYTE = 2'b00,
    SZ_HALF = 2'b01,
    SZ_WORD = 2'b10
  } mem_size_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_PC4,
    WB_LOAD
  } wb_src_e;

endpackage

/* verilog/rv_isa_pkg.sv */
/* RV32I encoding constants: widths, major opcodes and function fields.
   Shared by the core modules and the testbench. */
package rv_isa_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;
  localparam int MEM_WORDS  = 2048;

  // major opcodes, insn[6:0]
  typedef enum logic [6:0] {
    OP_LOAD     = 7'b0000011,
    OP_MISC_MEM = 7'b0001111,
    OP_IMM      = 7'b0010011,
    OP_AUIPC    = 7'b0010111,
    OP_STORE    = 7'b0100011,
    OP_REG      = 7'b0110011,
    OP_LUI      = 7'b0110111,
    OP_BRANCH   = 7'b1100011,
    OP_JALR     = 7'b1100111,
    OP_JAL      = 7'b1101111,
    OP_SYSTEM   = 7'b1110011
  } opcode_e;

  // funct7 selecting SUB and SRA/SRAI
  localparam logic [6:0] F7_ALT = 7'b0100000;

  // funct3 of the ALU group, shared by register and immediate forms
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // funct3 of the conditional branches
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

endpackage
